// ==== Bender.yml ====
package:
  name: wh_adapters

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/wh_pkg.sv
      - verilog/wh_seq_if.sv
      - verilog/wh_flit_counter.sv
      - verilog/wh_ser_fsm.sv
      - verilog/wh_deser_fsm.sv
      - verilog/wh_flit_piso.sv
      - verilog/wh_flit_sipo.sv
      - verilog/wh_adapters_top.sv
  - target: test
    include_dirs:
      - verilog
      - verif
    files:
      - verif/wh_assertions.sv
      - verif/tb_wh_adapters.sv

// ==== verif/wh_tests.svh ====
`ifndef WH_TESTS_SVH
`define WH_TESTS_SVH

task automatic test_reset_values();
  apply_reset();
  check_value("reset", "v_o at release", 0, v_out);
  check_value("reset", "ready_o at release", 0, ready);
  @(negedge clk);
  check_value("reset", "ready_o one cycle later", 1, ready);
  check_value("reset", "v_o one cycle later", 0, v_out);
endtask

// len 0 is a lone header flit
task automatic test_single_flit();
  wh_packet_t p;
  wh_packet_t exp;
  int         lat;
  p = random_packet('0);
  p.payload[`WH_FLIT_W-`WH_LEN_W-`WH_CORD_W-1:0] = '0;  // payload bits sharing the header
  exp      = '0;
  exp.cord = p.cord;
  exp.len  = p.len;
  exp_q.push_back(exp);
  send_packet("single_flit", p);
  wait_valid("single_flit", lat);
  check_value("single_flit", "latency", 2, lat);
  take_packet("single_flit");
endtask

task automatic test_full_length();
  wh_packet_t p;
  int         lat;
  for (int len = 1; len <= `WH_MAX_LEN; len++) begin
    p = random_packet(len[`WH_LEN_W-1:0]);
    exp_q.push_back(expected_packet(p));
    send_packet("full_length", p);
    wait_valid("full_length", lat);
    check_value("full_length", "latency", len + 2, lat);
    take_packet("full_length");
  end
endtask

// consumer takes every packet as soon as it shows up
task automatic test_back_to_back();
  fork
    begin
      wh_packet_t  p;
      logic [63:0] r;
      for (int i = 0; i < 10; i++) begin
        r = rand_bits(2);
        p = random_packet(r[`WH_LEN_W-1:0]);
        exp_q.push_back(expected_packet(p));
        send_packet("back_to_back", p);
      end
    end
    begin
      int lat;
      for (int i = 0; i < 10; i++) begin
        wait_valid("back_to_back", lat);
        take_packet("back_to_back");
      end
    end
  join
endtask

task automatic test_back_pressure();
  wh_packet_t       pa;
  wh_packet_t       pb;
  logic [PKT_W-1:0] held;
  int               lat;
  pa = random_packet(3'd3);
  pb = random_packet(3'd2);
  exp_q.push_back(expected_packet(pa));
  send_packet("back_pressure", pa);
  wait_valid("back_pressure", lat);
  held = packet_out;

  // second packet goes out on the link and stalls behind the first
  exp_q.push_back(expected_packet(pb));
  send_packet("back_pressure", pb);
  for (int i = 0; i < 20; i++) begin
    @(negedge clk);
    check_value("back_pressure", "v_o while held", 1, v_out);
    check_value("back_pressure", "packet_o while held", held, packet_out);
    check_value("back_pressure", "ready_o with a packet in flight", 0, ready);
  end

  take_packet("back_pressure");
  wait_valid("back_pressure", lat);
  take_packet("back_pressure");
endtask

`endif

// ==== verif/tb_wh_adapters.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wh_consts.svh"

module tb_wh_adapters;

  import wh_pkg::*;

  localparam int PKT_W      = $bits(wh_packet_t);
  localparam int WAIT_LIMIT = 200;  // cycles allowed for any single wait

  logic             clk;
  logic             arst_n;
  logic [PKT_W-1:0] packet_in;
  logic             v_in;
  logic             ready;
  logic [PKT_W-1:0] packet_out;
  logic             v_out;
  logic             yumi;

  logic [31:0]      lfsr_q;
  wh_packet_t       exp_q[$];  // packets in flight with the oldest first
  int               value_errors;
  int               timeouts;

  wh_adapters_top uut (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .packet_i (packet_in),
    .v_i      (v_in),
    .ready_o  (ready),
    .packet_o (packet_out),
    .v_o      (v_out),
    .yumi_i   (yumi)
  );

  always #20 clk = ~clk;

  // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r[i]   = lfsr_q[0];  // one step per bit
    end
    return r;
  endfunction

  function automatic wh_packet_t random_packet(input logic [`WH_LEN_W-1:0] len);
    wh_packet_t  p;
    logic [63:0] r;
    r         = rand_bits(`WH_CORD_W);
    p.cord    = r[`WH_CORD_W-1:0];
    p.len     = len;
    r         = rand_bits(`WH_PAYLOAD_W);
    p.payload = r[`WH_PAYLOAD_W-1:0];
    return p;
  endfunction

  // only the header and len body flits travel and the rest reads back as zero
  function automatic wh_packet_t expected_packet(input wh_packet_t p);
    logic [PKT_W-1:0] bits;
    int               kept;
    bits = p;
    kept = (int'(p.len) + 1) * `WH_FLIT_W;
    for (int i = 0; i < PKT_W; i++) begin
      if (i >= kept) begin
        bits[i] = 1'b0;
      end
    end
    return bits;
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      value_errors++;
      $display("[ERROR] %s: %s expected %h actual %h", test, what, exp, act);
    end
  endtask

  task automatic report_timeout(input string test, input string what);
    timeouts++;
    $display("%s: gave up waiting for %s after %0d cycles", test, what, WAIT_LIMIT);
  endtask

  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
  endtask

  // starts just after a falling edge and returns at the falling edge after the accept
  task automatic send_packet(input string test, input wh_packet_t p);
    int waited;
    packet_in = p;
    v_in      = 1'b1;
    waited    = 0;
    while (!ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (ready) begin
      @(negedge clk);  // accepted on the rising edge in between
      v_in = 1'b0;
    end else begin
      v_in = 1'b0;
      report_timeout(test, "ready_o");
    end
  endtask

  // lat counts cycles from the accept cycle to the first cycle with v_o
  task automatic wait_valid(input string test, output int lat);
    lat = 1;
    while (!v_out && lat < WAIT_LIMIT) begin
      @(negedge clk);
      lat++;
    end
    if (!v_out) begin
      report_timeout(test, "v_o");
    end
  endtask

  task automatic take_packet(input string test);
    wh_packet_t exp;
    if (exp_q.size() == 0) begin
      value_errors++;
      $display("%s: a packet came out while none was expected", test);
    end else begin
      exp = exp_q.pop_front();
      check_value(test, "packet_o", exp, packet_out);
    end
    yumi = 1'b1;
    @(negedge clk);
    yumi = 1'b0;
    check_value(test, "v_o after yumi", 0, v_out);
  endtask

  `include "wh_tests.svh"

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    packet_in    = '0;
    v_in         = 1'b0;
    yumi         = 1'b0;
    lfsr_q       = 32'h442a;
    value_errors = 0;
    timeouts     = 0;

    test_reset_values();
    test_single_flit();
    test_full_length();
    test_back_to_back();
    test_back_pressure();
    repeat (4) @(negedge clk);

    $display("value errors: %0d, timeouts: %0d, assertion failures: %0d",
             value_errors, timeouts, uut.protocol_checks.fail_count);
    if (value_errors == 0 && timeouts == 0 && uut.protocol_checks.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // whole-run limit on top of the per-wait limits
  initial begin
    #1000000;
    $display("simulation ran past its time limit");
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/wh_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wh_consts.svh"

module wh_protocol_assertions (
  input logic                                  clk_i,
  input logic                                  arst_n_i,
  input logic [$bits(wh_pkg::wh_packet_t)-1:0] pkt_out_i,
  input logic                                  v_out_i,
  input logic                                  yumi_i,
  input logic                                  link_v_i,
  input logic                                  link_ready_i,
  input logic [`WH_FLIT_W-1:0]                 link_data_i,
  input logic                                  hdr_load_i
);

  int unsigned fail_count = 0;

  out_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      v_out_i && !yumi_i |=> v_out_i && $stable(pkt_out_i))
    else begin
      fail_count++;
      $error("packet output dropped or changed before yumi");
    end

  link_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      link_v_i && !link_ready_i |=> link_v_i && $stable(link_data_i))
    else begin
      fail_count++;
      $error("flit dropped or changed while the link was stalled");
    end

  yumi_legal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      yumi_i |-> v_out_i)
    else begin
      fail_count++;
      $error("yumi without a valid packet");
    end

  // len sits right above cord in the header flit
  hdr_len: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      hdr_load_i |-> link_data_i[`WH_CORD_W +: `WH_LEN_W] <= `WH_MAX_LEN)
    else begin
      fail_count++;
      $error("header len above the largest legal value");
    end

endmodule

bind wh_adapters_top wh_protocol_assertions protocol_checks (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .pkt_out_i    (packet_o),
  .v_out_i      (v_o),
  .yumi_i       (yumi_i),
  .link_v_i     (link_v),
  .link_ready_i (link_ready),
  .link_data_i  (link_data),
  .hdr_load_i   (rx_seq.load)
);

`default_nettype wire

// ==== verilog/wh_adapters_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wh_consts.svh"

module wh_adapters_top (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [$bits(wh_pkg::wh_packet_t)-1:0] packet_i,
  input  logic                                v_i,
  output logic                                ready_o,
  output logic [$bits(wh_pkg::wh_packet_t)-1:0] packet_o,
  output logic                                v_o,
  input  logic                                yumi_i
);

  // flit link looped back from tx to rx
  logic                  link_v;
  logic                  link_ready;
  logic [`WH_FLIT_W-1:0] link_data;

  logic [`WH_LEN_W-1:0]  tx_len;
  logic [`WH_LEN_W-1:0]  rx_len;

  wh_seq_if tx_seq ();
  wh_seq_if rx_seq ();

  wh_ser_fsm tx_fsm (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .seq          (tx_seq.fsm),
    .v_i          (v_i),
    .ready_o      (ready_o),
    .link_v_o     (link_v),
    .link_ready_i (link_ready)
  );

  wh_flit_piso tx_piso (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .seq      (tx_seq.data),
    .packet_i (packet_i),
    .len_o    (tx_len),
    .flit_o   (link_data)
  );

  wh_flit_counter tx_cnt (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .seq      (tx_seq.counter),
    .len_i    (tx_len)
  );

  wh_deser_fsm rx_fsm (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .seq          (rx_seq.fsm),
    .link_v_i     (link_v),
    .link_ready_o (link_ready),
    .v_o          (v_o),
    .yumi_i       (yumi_i)
  );

  wh_flit_sipo rx_sipo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .seq      (rx_seq.data),
    .flit_i   (link_data),
    .len_o    (rx_len),
    .packet_o (packet_o)
  );

  wh_flit_counter rx_cnt (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .seq      (rx_seq.counter),
    .len_i    (rx_len)
  );

endmodule

`default_nettype wire

// ==== verilog/wh_consts.svh ====
`ifndef WH_CONSTS_SVH
`define WH_CONSTS_SVH

// packet fields
`define WH_CORD_W     4
`define WH_LEN_W      3
`define WH_PAYLOAD_W  48

// link and flit limits
`define WH_FLIT_W     16
`define WH_MAX_FLITS  4   // 55 packet bits in whole flits
`define WH_MAX_LEN    3   // body flits after the header
`define WH_IDX_W      2

`endif

// ==== verilog/wh_deser_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module wh_deser_fsm (
  input  logic  clk_i,
  input  logic  arst_n_i,
  wh_seq_if.fsm seq,
  input  logic  link_v_i,
  output logic  link_ready_o,
  output logic  v_o,
  input  logic  yumi_i
);

  import wh_pkg::*;

  deser_state_e state_q;
  deser_state_e state_d;
  logic         xfer;

  assign link_ready_o = (state_q != DES_FULL);  // no room while a packet waits
  assign v_o          = (state_q == DES_FULL);
  assign xfer         = link_v_i & link_ready_o;

  // the header is counted as flit 0 as well
  assign seq.load = xfer & (state_q == DES_HEAD);
  assign seq.step = xfer;

  always_comb begin
    state_d = state_q;
    case (state_q)
      DES_HEAD: begin
        if (xfer) begin
          state_d = seq.last ? DES_FULL : DES_BODY;  // len 0 ends here
        end
      end
      DES_BODY: begin
        if (xfer && seq.last) begin
          state_d = DES_FULL;
        end
      end
      DES_FULL: begin
        if (yumi_i) begin
          state_d = DES_HEAD;
        end
      end
      default: begin
        state_d = DES_HEAD;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= DES_HEAD;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wh_flit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wh_consts.svh"

module wh_flit_counter (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  wh_seq_if.counter            seq,
  input  logic [`WH_LEN_W-1:0] len_i
);

  localparam int IDX_W = `WH_IDX_W;
  localparam int LEN_W = `WH_LEN_W;

  logic [IDX_W-1:0] idx_q;

  // load restarts the count, so a header is always flit 0
  assign seq.idx  = seq.load ? '0 : idx_q;
  assign seq.last = (LEN_W'(seq.idx) == len_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      idx_q <= '0;
    end else if (seq.load || seq.step) begin
      idx_q <= seq.idx + IDX_W'(seq.step);  // wraps after the last flit
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wh_flit_piso.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wh_consts.svh"

module wh_flit_piso (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  wh_seq_if.data                seq,
  input  wh_pkg::wh_packet_t    packet_i,
  output logic [`WH_LEN_W-1:0]  len_o,
  output logic [`WH_FLIT_W-1:0] flit_o
);

  import wh_pkg::*;

  localparam int FLIT_W = `WH_FLIT_W;
  localparam int BUF_W  = `WH_MAX_FLITS * `WH_FLIT_W;
  localparam int PKT_W  = $bits(wh_packet_t);

  logic [BUF_W-1:0] buf_q;
  wh_packet_t       pkt;

  assign pkt    = buf_q[PKT_W-1:0];
  assign len_o  = pkt.len;
  assign flit_o = buf_q[seq.idx*FLIT_W +: FLIT_W];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buf_q <= '0;
    end else if (seq.load) begin
      buf_q <= {{(BUF_W-PKT_W){1'b0}}, packet_i};  // top flit padded with zeros
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wh_flit_sipo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wh_consts.svh"

module wh_flit_sipo (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  wh_seq_if.data                seq,
  input  logic [`WH_FLIT_W-1:0] flit_i,
  output logic [`WH_LEN_W-1:0]  len_o,
  output wh_pkg::wh_packet_t    packet_o
);

  import wh_pkg::*;

  localparam int MAX_FLITS = `WH_MAX_FLITS;
  localparam int FLIT_W    = `WH_FLIT_W;
  localparam int HDR_W     = $bits(wh_header_t);
  localparam int PKT_W     = $bits(wh_packet_t);

  logic [MAX_FLITS-1:0][FLIT_W-1:0] slot_q;
  logic [MAX_FLITS*FLIT_W-1:0]      slot_flat;
  wh_header_t                       hdr_in;
  wh_header_t                       hdr_q;

  assign hdr_in = flit_i[HDR_W-1:0];
  assign hdr_q  = slot_q[0][HDR_W-1:0];

  // the counter needs the new len before the header is stored
  assign len_o = seq.load ? hdr_in.len : hdr_q.len;

  assign slot_flat = slot_q;
  assign packet_o  = slot_flat[PKT_W-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_q <= '0;
    end else if (seq.load) begin
      slot_q    <= '0;  // stale body flits of a longer packet go away
      slot_q[0] <= flit_i;
    end else if (seq.step) begin
      slot_q[seq.idx] <= flit_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wh_pkg.sv ====
`default_nettype none

`include "wh_consts.svh"

package wh_pkg;

  // low bits of every header flit
  typedef struct packed {
    logic [`WH_LEN_W-1:0]  len;
    logic [`WH_CORD_W-1:0] cord;
  } wh_header_t;

  typedef struct packed {
    logic [`WH_PAYLOAD_W-1:0] payload;
    logic [`WH_LEN_W-1:0]     len;
    logic [`WH_CORD_W-1:0]    cord;
  } wh_packet_t;

  typedef enum logic [1:0] {
    SER_IDLE,
    SER_SEND
  } ser_state_e;

  typedef enum logic [1:0] {
    DES_HEAD,  // waiting for a header
    DES_BODY,
    DES_FULL   // packet held until yumi
  } deser_state_e;

endpackage

`default_nettype wire

// ==== verilog/wh_seq_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wh_consts.svh"

interface wh_seq_if;

  logic                 load;
  logic                 step;
  logic [`WH_IDX_W-1:0] idx;
  logic                 last;  // idx has reached the packet len

  modport fsm     (output load, output step, input last);
  modport counter (input load, input step, output idx, output last);
  modport data    (input load, input step, input idx);

endinterface

`default_nettype wire

// ==== verilog/wh_ser_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module wh_ser_fsm (
  input  logic  clk_i,
  input  logic  arst_n_i,
  wh_seq_if.fsm seq,
  input  logic  v_i,
  output logic  ready_o,
  output logic  link_v_o,
  input  logic  link_ready_i
);

  import wh_pkg::*;

  ser_state_e state_q;
  ser_state_e state_d;
  logic       ready_q;
  logic       xfer;

  assign xfer     = link_v_o & link_ready_i;
  assign link_v_o = (state_q == SER_SEND);
  assign ready_o  = ready_q;

  assign seq.load = ready_q & v_i;  // packet handshake
  assign seq.step = xfer;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SER_IDLE: begin
        if (seq.load) begin
          state_d = SER_SEND;
        end
      end
      SER_SEND: begin
        if (xfer && seq.last) begin
          state_d = SER_IDLE;
        end
      end
      default: begin
        state_d = SER_IDLE;
      end
    endcase
  end

  // ready follows the next state and stays low in reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SER_IDLE;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == SER_IDLE);
    end
  end

endmodule

`default_nettype wire

// ==== wh_adapters.f ====
+incdir+verilog
+incdir+verif
verilog/wh_pkg.sv
verilog/wh_seq_if.sv
verilog/wh_flit_counter.sv
verilog/wh_ser_fsm.sv
verilog/wh_deser_fsm.sv
verilog/wh_flit_piso.sv
verilog/wh_flit_sipo.sv
verilog/wh_adapters_top.sv
verif/wh_assertions.sv
verif/tb_wh_adapters.sv
